/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f flist.f --top-module soc_board

sim:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f \
		--top-module tb_soc_board -o tb_soc_board
	./obj_dir/tb_soc_board | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* flist.f */
hdl/soc_pkg.sv
hdl/wb_bus_if.sv
hdl/wb_addr_decoder.sv
hdl/word_memory.sv
hdl/ps2_keyboard.sv
hdl/console_tx.sv
hdl/irq_controller.sv
hdl/soc_board.sv
tb/tb_soc_board.sv

/* hdl/console_tx.sv */
`default_nettype none

module console_tx
    import soc_pkg::*;
#(
    parameter int clks_per_bit = 434
) (
    input  logic    clk,
    input  logic    rst_n,
    wb_bus_if.slave bus,
    output logic    txd,
    output logic    con_done
);

    localparam int               cnt_w    = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);

    logic [10:0]      shreg;
    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic             busy;
    logic             hit;
    logic             send;
    logic             bit_end;

    // bus decode
    assign hit  = bus.cyc && bus.stb && !bus.ack;

    // writes while busy are acked and dropped
    assign send = hit && bus.we && !busy && (bus.adr == con_data_addr);

    // last clock of the current bit
    assign bit_end = busy && (clk_cnt == cnt_last);

    // line is the low end of the shifter
    assign txd = shreg[0];

    // frame is a one clock idle slot then start, data lsb first, stop
    // bit_cnt tracks which slot is on the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shreg    <= '1;
            clk_cnt  <= '0;
            bit_cnt  <= 4'd0;
            busy     <= 1'b0;
            con_done <= 1'b0;
        end else begin
            con_done <= 1'b0;
            if (send) begin
                shreg   <= {1'b1, bus.dat_w[7:0], 1'b0, 1'b1};
                // idle slot lasts a single clock
                clk_cnt <= cnt_last;
                bit_cnt <= 4'd0;
                busy    <= 1'b1;
            end else if (bit_end) begin
                shreg   <= {1'b1, shreg[10:1]};
                clk_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    // stop bit just finished
                    busy     <= 1'b0;
                    con_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (busy) begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // single cycle ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= hit;
        end
    end

    // data register reads back zero
    always_ff @(posedge clk) begin
        if (hit) begin
            if (bus.adr == con_stat_addr) begin
                bus.dat_r <= {{(data_w-1){1'b0}}, busy};
            end else begin
                bus.dat_r <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/irq_controller.sv */
`default_nettype none

module irq_controller
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       kbd_event,
    input  logic       con_done,
    input  logic       irq_ack,
    output logic [3:0] irq_vector,
    output logic       irq_pending
);

    logic pend_kbd;
    logic pend_con;
    logic kbd_next;
    logic con_next;

    // ack retires the flag behind the shown vector
    // an ack against vector zero matches neither source
    // a pulse sets its flag again or merges into it
    assign kbd_next = (pend_kbd && !(irq_ack && irq_vector == vec_keyboard)) || kbd_event;
    assign con_next = (pend_con && !(irq_ack && irq_vector == vec_console)) || con_done;

    // flags and vector move on the same edge
    // keyboard outranks console
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_kbd   <= 1'b0;
            pend_con   <= 1'b0;
            irq_vector <= vec_none;
        end else begin
            pend_kbd <= kbd_next;
            pend_con <= con_next;
            if (kbd_next) begin
                irq_vector <= vec_keyboard;
            end else if (con_next) begin
                irq_vector <= vec_console;
            end else begin
                irq_vector <= vec_none;
            end
        end
    end

    // red led
    assign irq_pending = pend_kbd || pend_con;

endmodule

`default_nettype wire

/* hdl/ps2_keyboard.sv */
`default_nettype none

module ps2_keyboard
    import soc_pkg::*;
#(
    parameter int ps2_filter = 3
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    wb_bus_if.slave    bus,
    output logic       kbd_event,
    output logic [7:0] scan_code
);

    logic [ps2_filter-1:0] clk_sync;
    logic [ps2_filter-1:0] dat_sync;
    logic                  clk_prev;
    logic                  fall;
    logic                  bit_in;
    logic [3:0]            bit_cnt;
    logic [8:0]            shreg;
    logic                  valid;
    logic                  parity_err;
    logic                  hit;
    logic                  rd_data;
    logic                  rd_stat;

    // both lines through the same depth so data lines up with clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[ps2_filter-2:0], ps2_clk};
            dat_sync <= {dat_sync[ps2_filter-2:0], ps2_dat};
            clk_prev <= clk_sync[ps2_filter-1];
        end
    end

    // device changes data while clock is high
    // sample on the falling edge
    assign fall   = clk_prev && !clk_sync[ps2_filter-1];
    assign bit_in = dat_sync[ps2_filter-1];

    // bus decode
    assign hit     = bus.cyc && bus.stb && !bus.ack;
    assign rd_data = hit && !bus.we && (bus.adr == kbd_data_addr);
    assign rd_stat = hit && !bus.we && (bus.adr == kbd_stat_addr);

    // data bits then parity, lsb first
    always_ff @(posedge clk) begin
        if (fall && bit_cnt != 4'd0 && bit_cnt < 4'd10) begin
            shreg <= {bit_in, shreg[8:1]};
        end
    end

    // frame counter and result registers
    // bit_cnt 0 idle, 1..9 data and parity, 10 stop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= 4'd0;
            kbd_event  <= 1'b0;
            valid      <= 1'b0;
            parity_err <= 1'b0;
            scan_code  <= 8'd0;
        end else begin
            kbd_event <= 1'b0;
            // reads clear first so a new frame on the same edge wins
            if (rd_data) begin
                valid <= 1'b0;
            end
            if (rd_stat) begin
                parity_err <= 1'b0;
            end
            if (fall) begin
                if (bit_cnt == 4'd0) begin
                    // only a low start bit opens a frame
                    if (!bit_in) begin
                        bit_cnt <= 4'd1;
                    end
                end else if (bit_cnt < 4'd10) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    bit_cnt <= 4'd0;
                    // odd parity over data plus parity bit
                    if (bit_in && ^shreg) begin
                        scan_code <= shreg[7:0];
                        valid     <= 1'b1;
                        kbd_event <= 1'b1;
                    end else if (bit_in) begin
                        parity_err <= 1'b1;
                    end
                end
            end
        end
    end

    // single cycle ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= hit;
        end
    end

    // read data, status shows flags before this read clears them
    always_ff @(posedge clk) begin
        if (hit) begin
            if (bus.adr == kbd_stat_addr) begin
                bus.dat_r <= {{(data_w-2){1'b0}}, parity_err, valid};
            end else begin
                bus.dat_r <= {{(data_w-8){1'b0}}, scan_code};
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/soc_board.sv */
`default_nettype none

module soc_board
    import soc_pkg::*;
#(
    parameter int mem_words    = 2048,
    parameter int clks_per_bit = 434,
    parameter int ps2_filter   = 3
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              PS2_CLK,
    input  logic              PS2_DAT,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [addr_w-1:0] wb_adr,
    input  logic [data_w-1:0] wb_dat_w,
    input  logic              irq_ack,
    output logic [data_w-1:0] wb_dat_r,
    output logic              wb_ack,
    output logic [3:0]        irq_vector,
    output logic              uart_txd,
    output logic [7:0]        LEDG,
    output logic              LEDR7
);

    // one bus per target
    wb_bus_if mem_bus ();
    wb_bus_if kbd_bus ();
    wb_bus_if con_bus ();

    // interrupt sources
    logic kbd_event;
    logic con_done;

    // cpu side bus enters here
    wb_addr_decoder u_decoder (
        .clk     (CLOCK_50),
        .rst_n   (KEY0),
        .cyc     (wb_cyc),
        .stb     (wb_stb),
        .we      (wb_we),
        .adr     (wb_adr),
        .dat_w   (wb_dat_w),
        .dat_r   (wb_dat_r),
        .ack     (wb_ack),
        .mem_bus (mem_bus),
        .kbd_bus (kbd_bus),
        .con_bus (con_bus)
    );

    // boot and program image
    word_memory #(
        .mem_words (mem_words)
    ) u_memory (
        .clk (CLOCK_50),
        .bus (mem_bus)
    );

    // last scan code goes to the green leds
    ps2_keyboard #(
        .ps2_filter (ps2_filter)
    ) u_keyboard (
        .clk       (CLOCK_50),
        .rst_n     (KEY0),
        .ps2_clk   (PS2_CLK),
        .ps2_dat   (PS2_DAT),
        .bus       (kbd_bus),
        .kbd_event (kbd_event),
        .scan_code (LEDG)
    );

    // serial console
    console_tx #(
        .clks_per_bit (clks_per_bit)
    ) u_console (
        .clk      (CLOCK_50),
        .rst_n    (KEY0),
        .bus      (con_bus),
        .txd      (uart_txd),
        .con_done (con_done)
    );

    // pending flag lights LEDR7
    irq_controller u_irq (
        .clk         (CLOCK_50),
        .rst_n       (KEY0),
        .kbd_event   (kbd_event),
        .con_done    (con_done),
        .irq_ack     (irq_ack),
        .irq_vector  (irq_vector),
        .irq_pending (LEDR7)
    );

endmodule

`default_nettype wire

/* hdl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // bus geometry
    localparam int addr_w = 16;
    localparam int data_w = 32;

    // memory region
    // 8 KB of words from the bottom of the map
    localparam logic [addr_w-1:0] mem_base = 16'h0000;
    localparam logic [addr_w-1:0] mem_top  = 16'h1FFF;

    // keyboard registers
    // data holds the scan code in 7:0
    // status bit 0 is byte valid and bit 1 is the sticky parity error
    localparam logic [addr_w-1:0] kbd_data_addr = 16'hFFF0;
    localparam logic [addr_w-1:0] kbd_stat_addr = 16'hFFF4;

    // console registers
    // a data write sends 7:0 and status bit 0 is busy
    localparam logic [addr_w-1:0] con_data_addr = 16'hFFF8;
    localparam logic [addr_w-1:0] con_stat_addr = 16'hFFFC;

    // returned for any unmapped read
    localparam logic [data_w-1:0] bus_fill_word = 32'hDEADBEEF;

    // interrupt vector codes
    localparam logic [3:0] vec_none     = 4'd0;
    localparam logic [3:0] vec_keyboard = 4'd1;
    localparam logic [3:0] vec_console  = 4'd2;

    // decoder target
    typedef enum logic [1:0] {
        tgt_mem,
        tgt_kbd,
        tgt_con,
        tgt_none
    } target_e;

endpackage

`default_nettype wire

/* hdl/wb_addr_decoder.sv */
`default_nettype none

module wb_addr_decoder
    import soc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [addr_w-1:0] adr,
    input  logic [data_w-1:0] dat_w,
    output logic [data_w-1:0] dat_r,
    output logic              ack,
    wb_bus_if.master          mem_bus,
    wb_bus_if.master          kbd_bus,
    wb_bus_if.master          con_bus
);

    target_e           sel;
    logic [addr_w-1:0] mem_off;
    logic              req;
    logic              none_ack;

    // offset into the memory window
    assign mem_off = adr - mem_base;
    assign req     = cyc && stb;

    // address map lookup
    always_comb begin
        if (mem_off <= mem_top - mem_base) begin
            sel = tgt_mem;
        end else if (adr == kbd_data_addr || adr == kbd_stat_addr) begin
            sel = tgt_kbd;
        end else if (adr == con_data_addr || adr == con_stat_addr) begin
            sel = tgt_con;
        end else begin
            sel = tgt_none;
        end
    end

    // every slave sees the full request
    // only the selected one gets a strobe
    assign mem_bus.cyc   = cyc;
    assign mem_bus.stb   = req && (sel == tgt_mem);
    assign mem_bus.we    = we;
    assign mem_bus.adr   = adr;
    assign mem_bus.dat_w = dat_w;

    assign kbd_bus.cyc   = cyc;
    assign kbd_bus.stb   = req && (sel == tgt_kbd);
    assign kbd_bus.we    = we;
    assign kbd_bus.adr   = adr;
    assign kbd_bus.dat_w = dat_w;

    assign con_bus.cyc   = cyc;
    assign con_bus.stb   = req && (sel == tgt_con);
    assign con_bus.we    = we;
    assign con_bus.adr   = adr;
    assign con_bus.dat_w = dat_w;

    // unmapped hole answers by itself one clock later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= req && (sel == tgt_none) && !none_ack;
        end
    end

    // response mux
    // address is held until ack so sel stays valid
    always_comb begin
        case (sel)
            tgt_mem: begin
                dat_r = mem_bus.dat_r;
                ack   = mem_bus.ack;
            end
            tgt_kbd: begin
                dat_r = kbd_bus.dat_r;
                ack   = kbd_bus.ack;
            end
            tgt_con: begin
                dat_r = con_bus.dat_r;
                ack   = con_bus.ack;
            end
            default: begin
                dat_r = bus_fill_word;
                ack   = none_ack;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/wb_bus_if.sv */
`default_nettype none

interface wb_bus_if
    import soc_pkg::*;
();

    // classic cycle, one word per transfer
    logic              cyc;
    logic              stb;
    logic              we;
    logic [addr_w-1:0] adr;
    logic [data_w-1:0] dat_w;

    // slave response
    logic [data_w-1:0] dat_r;
    logic              ack;

    // decoder side
    modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);

    // peripheral side
    modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

`default_nettype wire

/* hdl/word_memory.sv */
`default_nettype none

module word_memory
    import soc_pkg::*;
#(
    parameter int mem_words = 2048
) (
    input logic     clk,
    wb_bus_if.slave bus
);

    localparam int idx_w = $clog2(mem_words);

    // block ram style array
    logic [data_w-1:0] mem [mem_words];
    logic [idx_w-1:0]  idx;
    logic              hit;

    // word index, byte offset bits dropped
    assign idx = bus.adr[idx_w+1:2];

    // first cycle of a strobe
    assign hit = bus.cyc && bus.stb && !bus.ack;

    // single cycle ack
    // clears itself once stb drops
    always_ff @(posedge clk) begin
        bus.ack <= hit;
    end

    // write lands on the acking edge
    // read data registered alongside ack
    always_ff @(posedge clk) begin
        if (hit && bus.we) begin
            mem[idx] <= bus.dat_w;
        end
        if (hit) begin
            bus.dat_r <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* tb/tb_soc_board.sv */
`default_nettype none

module tb_soc_board
    import soc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_depth = 2048;
    localparam int idx_w     = $clog2(mem_depth);
    localparam int bit_clks  = 16;
    localparam int ps2_half  = 10;
    localparam int ack_limit = 20;

    logic              clk;
    logic              key0;
    logic              ps2_clk;
    logic              ps2_dat;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [addr_w-1:0] wb_adr;
    logic [data_w-1:0] wb_dat_w;
    logic              irq_ack;
    logic [data_w-1:0] wb_dat_r;
    logic              wb_ack;
    logic [3:0]        irq_vector;
    logic              uart_txd;
    logic [7:0]        ledg;
    logic              ledr7;

    // reference model state
    logic [data_w-1:0] mem_model [mem_depth];
    logic [idx_w-1:0]  written [$];
    logic [7:0]        kbd_q [$];
    logic              kbd_valid;
    logic              kbd_err;
    logic [7:0]        con_q [$];
    logic              pend_kbd;
    logic              pend_con;
    int                errors;
    int                timeouts;

    soc_board #(
        .mem_words    (mem_depth),
        .clks_per_bit (bit_clks),
        .ps2_filter   (3)
    ) UUT (
        .CLOCK_50   (clk),
        .KEY0       (key0),
        .PS2_CLK    (ps2_clk),
        .PS2_DAT    (ps2_dat),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .irq_ack    (irq_ack),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .irq_vector (irq_vector),
        .uart_txd   (uart_txd),
        .LEDG       (ledg),
        .LEDR7      (ledr7)
    );

    // 50 MHz board clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // map lookup from the address table
    function automatic target_e target_of(input logic [addr_w-1:0] a);
        if (a >= mem_base && a <= mem_top) begin
            return tgt_mem;
        end else if (a == kbd_data_addr || a == kbd_stat_addr) begin
            return tgt_kbd;
        end else if (a == con_data_addr || a == con_stat_addr) begin
            return tgt_con;
        end
        return tgt_none;
    endfunction

    function automatic logic [data_w-1:0] model_read(input logic [addr_w-1:0] a);
        case (target_of(a))
            tgt_mem: return mem_model[a[idx_w+1:2]];
            default: return bus_fill_word;
        endcase
    endfunction

    // keyboard outranks console
    function automatic logic [3:0] expected_vector();
        if (pend_kbd) begin
            return vec_keyboard;
        end else if (pend_con) begin
            return vec_console;
        end
        return vec_none;
    endfunction

    task automatic check_word(input string name, input logic [data_w-1:0] expected,
                              input logic [data_w-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // one classic cycle, ack sampled on falling edges
    task automatic bus_cycle(input logic we, input logic [addr_w-1:0] adr,
                             input logic [data_w-1:0] wdata,
                             output logic [data_w-1:0] rdata);
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        rdata  = '0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        while (!seen && waited < ack_limit) begin
            @(negedge clk);
            waited++;
            if (wb_ack) begin
                seen  = 1'b1;
                rdata = wb_dat_r;
            end
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!seen) begin
            $display("timeout: no wb_ack for the access to address %h", adr);
            timeouts++;
        end else if (waited != 2) begin
            // second falling edge is one clock after the strobe is sampled
            $display("ERR %0t wb_ack latency expected 1 actual %0d", $time, waited - 1);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [addr_w-1:0] adr, input logic [data_w-1:0] wdata);
        logic [data_w-1:0] unused;
        bus_cycle(1'b1, adr, wdata, unused);
    endtask

    task automatic bus_read(input logic [addr_w-1:0] adr, output logic [data_w-1:0] rdata);
        bus_cycle(1'b0, adr, '0, rdata);
    endtask

    // device side frame, data changes while clock is high
    task automatic send_ps2(input logic [7:0] data, input bit good);
        logic [10:0] frame;
        frame = {1'b1, (good ? ~^data : ^data), data, 1'b0};
        repeat (11) begin
            @(posedge clk);
            ps2_dat <= frame[0];
            wait_clocks(ps2_half / 2);
            ps2_clk <= 1'b0;
            wait_clocks(ps2_half);
            ps2_clk <= 1'b1;
            wait_clocks(ps2_half / 2);
            frame = frame >> 1;
        end
    endtask

    // serial monitor, samples the middle of each bit
    task automatic capture_frame(output logic [7:0] data, output bit ok);
        int waited;
        logic [9:0] bits;
        waited = 0;
        bits   = '1;
        data   = '0;
        ok     = 1'b0;
        do begin
            @(negedge clk);
            waited++;
        end while (uart_txd !== 1'b0 && waited < 20 * bit_clks);
        if (uart_txd !== 1'b0) begin
            $display("timeout: no start bit on uart_txd");
            timeouts++;
        end else begin
            repeat (bit_clks / 2) @(negedge clk);
            bits = {uart_txd, bits[9:1]};
            repeat (9) begin
                repeat (bit_clks) @(negedge clk);
                bits = {uart_txd, bits[9:1]};
            end
            check_word("uart_txd start bit", 0, data_w'(bits[0]));
            check_word("uart_txd stop bit", 1, data_w'(bits[9]));
            data = bits[8:1];
            ok   = 1'b1;
        end
    endtask

    task automatic wait_vector(input logic [3:0] expected);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (irq_vector !== expected && waited < 4 * bit_clks);
        if (irq_vector !== expected) begin
            $display("timeout: irq_vector never reached %0d", expected);
            timeouts++;
        end
    endtask

    task automatic check_line_idle(input int cycles);
        bit bad;
        bad = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            if (uart_txd !== 1'b1) begin
                bad = 1'b1;
            end
        end
        if (bad) begin
            $display("ERR %0t uart_txd expected 1 actual 0", $time);
            errors++;
        end
    endtask

    // one clock acknowledge, then the next vector shows
    task automatic ack_irq();
        @(posedge clk);
        irq_ack <= 1'b1;
        @(posedge clk);
        irq_ack <= 1'b0;
        if (pend_kbd) begin
            pend_kbd = 1'b0;
        end else begin
            pend_con = 1'b0;
        end
        @(negedge clk);
        check_word("irq_vector", data_w'(expected_vector()), data_w'(irq_vector));
        check_word("LEDR7", data_w'(pend_kbd || pend_con), data_w'(ledr7));
    endtask

    task automatic keyboard_good(input logic [7:0] b);
        send_ps2(b, 1'b1);
        kbd_q.push_back(b);
        kbd_valid = 1'b1;
        pend_kbd  = 1'b1;
        @(negedge clk);
        check_word("LEDG", data_w'(b), data_w'(ledg));
        check_word("irq_vector", data_w'(expected_vector()), data_w'(irq_vector));
        check_word("LEDR7", 1, data_w'(ledr7));
    endtask

    task automatic read_kbd_status();
        logic [data_w-1:0] rd;
        bus_read(kbd_stat_addr, rd);
        check_word("kbd_stat", {30'd0, kbd_err, kbd_valid}, rd);
        kbd_err = 1'b0;
    endtask

    task automatic read_kbd_data();
        logic [data_w-1:0] rd;
        bus_read(kbd_data_addr, rd);
        check_word("kbd_data", {24'd0, kbd_q[$]}, rd);
        kbd_valid = 1'b0;
    endtask

    // one frame out, busy probed and a second write lost on the way
    task automatic console_byte(input logic [7:0] b);
        logic [7:0]        rx;
        logic [data_w-1:0] rd;
        bit                ok;
        bus_write(con_data_addr, {24'd0, b});
        con_q.push_back(b);
        fork
            capture_frame(rx, ok);
            begin
                bus_read(con_stat_addr, rd);
                check_word("con_stat", 1, rd);
                bus_write(con_data_addr, $urandom);
                bus_read(con_stat_addr, rd);
                check_word("con_stat", 1, rd);
            end
        join
        if (ok) begin
            check_word("uart_txd byte", data_w'(con_q.pop_front()), data_w'(rx));
        end
        pend_con = 1'b1;
        wait_vector(expected_vector());
        check_word("LEDR7", 1, data_w'(ledr7));
    endtask

    initial begin
        logic [idx_w-1:0]  widx;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [data_w-1:0] rd;
        void'($urandom(32'heeffc604));
        errors    = 0;
        timeouts  = 0;
        kbd_valid = 1'b0;
        kbd_err   = 1'b0;
        pend_kbd  = 1'b0;
        pend_con  = 1'b0;
        key0      = 1'b0;
        ps2_clk   = 1'b1;
        ps2_dat   = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        irq_ack   = 1'b0;
        repeat (16) @(posedge clk);
        key0 <= 1'b1;
        @(negedge clk);

        // idle state out of reset
        check_word("wb_ack", 0, data_w'(wb_ack));
        check_word("LEDR7", 0, data_w'(ledr7));
        check_word("LEDG", 0, data_w'(ledg));
        check_word("irq_vector", 0, data_w'(irq_vector));
        check_word("uart_txd", 1, data_w'(uart_txd));

        // memory, read back only words already written
        repeat (200) begin
            widx  = idx_w'($urandom);
            wdata = $urandom;
            addr  = {{(addr_w-idx_w-2){1'b0}}, widx, 2'b00};
            bus_write(addr, wdata);
            mem_model[widx] = wdata;
            written.push_back(widx);
            widx = written[$urandom % written.size()];
            addr = {{(addr_w-idx_w-2){1'b0}}, widx, 2'b00};
            bus_read(addr, rd);
            check_word("wb_dat_r", model_read(addr), rd);
        end

        // hole between memory and the register block
        repeat (20) begin
            addr = addr_w'(32'h2000 + ($urandom % 32'hDFF0));
            bus_read(addr, rd);
            check_word("wb_dat_r", model_read(addr), rd);
        end

        // keyboard with good parity
        repeat (6) begin
            keyboard_good(8'($urandom));
            read_kbd_status();
            read_kbd_data();
            read_kbd_status();
            ack_irq();
        end

        // bad parity while a byte is still unread
        keyboard_good(8'($urandom));
        ack_irq();
        send_ps2(8'($urandom), 1'b0);
        kbd_err = 1'b1;
        @(negedge clk);
        check_word("LEDG", data_w'(kbd_q[$]), data_w'(ledg));
        check_word("irq_vector", data_w'(expected_vector()), data_w'(irq_vector));
        check_word("LEDR7", 0, data_w'(ledr7));
        read_kbd_status();
        read_kbd_status();
        read_kbd_data();
        read_kbd_status();

        // console frames
        repeat (4) begin
            console_byte(8'($urandom));
            ack_irq();
            bus_read(con_stat_addr, rd);
            check_word("con_stat", 0, rd);
        end
        check_line_idle(12 * bit_clks);

        // console done first, keyboard byte before any ack
        console_byte(8'($urandom));
        keyboard_good(8'($urandom));
        ack_irq();
        ack_irq();
        read_kbd_data();

        $display("errors=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
